//--- all.f
logic/frontEndPkg.sv
logic/diagBusCycle.sv
logic/masterResetSeq.sv
logic/cramWordWriter.sv
logic/frontEndTop.sv
tests/clockGen.sv
tests/frontEndProperties.sv
tests/frontEndTb.sv

//--- logic/cramWordWriter.sv
// Control-RAM word access as seven back-to-back bus cycles; write done comes with the last bus done
`timescale 1ns/1ps

module cramWordWriter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     enable,
  input  logic                     writeReq,
  input  logic                     readReq,
  input  frontEndPkg::cramAddr     addr,
  input  frontEndPkg::cramWord     wordIn,
  input  logic                     cycleDone,
  input  frontEndPkg::ebusWord     cycleReadData,
  output logic                     cycleStart,
  output frontEndPkg::cycleKind    cycleKind,
  output frontEndPkg::diagFunction cycleFunc,
  output frontEndPkg::ebusWord     cycleData,
  output frontEndPkg::cramWord     wordOut,
  output logic                     busy,
  output logic                     done
);

  frontEndPkg::cramState state;
  // Index of the bus cycle in flight, 0 and 1 are the address halves
  logic [2:0] stepIdx;
  logic       lastDone;
  logic       readDone;
  frontEndPkg::cramAddr addrReg;
  frontEndPkg::cramWord wordReg;

  // Operands of the cycle being started now
  logic [2:0] issueStep;
  logic       issueRead;
  frontEndPkg::cramAddr issueAddr;
  frontEndPkg::cramWord issueWord;

  // Twenty slice bits as five groups of four, two zero bits between groups
  function automatic frontEndPkg::ebusWord spreadSlice(input logic [0:19] s);
    spreadSlice = {8'b0, s[0:3], 2'b0, s[4:7], 2'b0, s[8:11], 2'b0, s[12:15], 2'b0, s[16:19]};
  endfunction

  assign busy     = state != frontEndPkg::csIdle;
  assign lastDone = busy && cycleDone && stepIdx == 3'd6;

  // Write finishes with its last bus cycle, read one cycle later once wordOut is whole
  assign done = (state == frontEndPkg::csWrite && lastDone) || readDone;

  assign cycleStart = (!busy && enable && (writeReq || readReq))
                   || (busy && cycleDone && stepIdx != 3'd6);

  always_comb begin
    if (!busy) begin
      issueStep = 3'd0;
      issueRead = readReq && !writeReq;
      issueAddr = addr;
      issueWord = wordIn;
    end else begin
      issueStep = stepIdx + 3'd1;
      issueRead = state == frontEndPkg::csRead;
      issueAddr = addrReg;
      issueWord = wordReg;
    end
    cycleKind = (issueRead && issueStep >= 3'd2) ? frontEndPkg::cycRead : frontEndPkg::cycWrite;
    cycleData = '0;
    case (issueStep)
      3'd0: begin
        cycleFunc = frontEndPkg::fnCramAddrRh;
        cycleData = {issueAddr[5:10], 30'b0};
      end
      3'd1: begin
        cycleFunc = frontEndPkg::fnCramAddrLh;
        cycleData = {1'b0, issueAddr[0:4], 30'b0};
      end
      3'd2: begin
        // Only even bits of 60-79 go in, odd positions stay zero
        cycleFunc = issueRead ? frontEndPkg::fnCramRead00to19 : frontEndPkg::fnCramWrite60to79;
        cycleData = issueRead ? '0 : spreadSlice(issueWord[60:79] & 20'hAAAAA);
      end
      3'd3: begin
        cycleFunc = issueRead ? frontEndPkg::fnCramRead20to39 : frontEndPkg::fnCramWrite40to59;
        cycleData = issueRead ? '0 : spreadSlice(issueWord[40:59]);
      end
      3'd4: begin
        cycleFunc = issueRead ? frontEndPkg::fnCramRead40to59 : frontEndPkg::fnCramWrite20to39;
        cycleData = issueRead ? '0 : spreadSlice(issueWord[20:39]);
      end
      3'd5: begin
        cycleFunc = issueRead ? frontEndPkg::fnCramRead60to79 : frontEndPkg::fnCramWrite00to19;
        cycleData = issueRead ? '0 : spreadSlice(issueWord[0:19]);
      end
      default: begin
        // Special field {CALL,DISP} rides in bus bits 0-5
        cycleFunc = issueRead ? frontEndPkg::fnCramRead80to85 : frontEndPkg::fnCramWrite80to85;
        cycleData = issueRead ? '0 : {issueWord[80:85], 30'b0};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= frontEndPkg::csIdle;
      stepIdx  <= 3'd0;
      readDone <= 1'b0;
    end else begin
      readDone <= state == frontEndPkg::csRead && lastDone;
      if (!busy && cycleStart) begin
        state   <= issueRead ? frontEndPkg::csRead : frontEndPkg::csWrite;
        stepIdx <= 3'd0;
      end else if (lastDone) begin
        state <= frontEndPkg::csIdle;
      end else if (busy && cycleDone) begin
        stepIdx <= stepIdx + 3'd1;
      end
    end
  end

  // Operands held for the whole sequence, slices gathered as they return
  always_ff @(posedge clk) begin
    if (!busy && cycleStart) begin
      addrReg <= addr;
      wordReg <= wordIn;
    end
    if (state == frontEndPkg::csRead && cycleDone) begin
      case (stepIdx)
        3'd2: wordOut[0:19]  <= cycleReadData[0:19];
        3'd3: wordOut[20:39] <= cycleReadData[0:19];
        3'd4: wordOut[40:59] <= cycleReadData[0:19];
        3'd5: wordOut[60:79] <= cycleReadData[0:19];
        3'd6: wordOut[80:85] <= cycleReadData[0:5];
        default: ;
      endcase
    end
  end

endmodule

//--- logic/diagBusCycle.sv
// One diagnostic bus cycle per start pulse; start is taken only when idle or in the done cycle
`timescale 1ns/1ps

module diagBusCycle (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  frontEndPkg::cycleKind    kind,
  input  frontEndPkg::diagFunction func,
  input  frontEndPkg::ebusWord     writeData,
  input  frontEndPkg::ebusWord     ebusIn,
  output frontEndPkg::diagFunction diagFunc,
  output logic                     diagStrobe,
  output frontEndPkg::ebusWord     ebusOut,
  output logic                     ebusDriving,
  output frontEndPkg::ebusWord     readData,
  output logic                     done
);

  // Cycle position, 0 when idle, 1 to busCycleLen while running
  logic [3:0] phase;
  logic       accept;

  // Latched request
  frontEndPkg::cycleKind    kindReg;
  frontEndPkg::diagFunction funcReg;
  frontEndPkg::ebusWord     dataReg;

  //////////////////////////////
  // Window decode

  // Done is the last position of the count
  assign done = phase == 4'(frontEndPkg::busCycleLen);

  // Back-to-back requesters may restart in the done cycle
  assign accept = start && (phase == 4'd0 || done);

  // Strobe covers positions 1 through strobeCycles
  assign diagStrobe = phase >= 4'd1 && phase <= 4'(frontEndPkg::strobeCycles);

  // Drive opens with the strobe and holds one cycle past it
  assign ebusDriving = kindReg == frontEndPkg::cycWrite
                    && phase >= 4'd1
                    && phase <= 4'(frontEndPkg::strobeCycles + 1);

  // Bus reads zero when this side is not driving
  assign ebusOut = ebusDriving ? dataReg : '0;

  // Code is qualified by the strobe on the machine side
  assign diagFunc = funcReg;

  //////////////////////////////
  // Sequencing

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= 4'd0;
    end else if (accept) begin
      phase <= 4'd1;
    end else if (done) begin
      phase <= 4'd0;
    end else if (phase != 4'd0) begin
      phase <= phase + 4'd1;
    end
  end

  // Request fields, loaded when a cycle is taken
  always_ff @(posedge clk) begin
    if (accept) begin
      kindReg <= kind;
      funcReg <= func;
      dataReg <= writeData;
    end
  end

  // Read sample in the last strobe cycle, bus is settled by then
  always_ff @(posedge clk) begin
    if (kindReg == frontEndPkg::cycRead &&
        phase == 4'(frontEndPkg::strobeCycles)) begin
      readData <= ebusIn;
    end
  end

endmodule

//--- logic/frontEndPkg.sv
// Shared widths, diagnostic function codes and reset table; bit 0 of every bus and word is the MSB
package frontEndPkg;

  //////////////////////////////
  // Machine widths, numbered from the MSB as in the KL10 prints
  typedef logic [0:35] ebusWord;
  typedef logic [0:10] cramAddr;
  typedef logic [0:85] cramWord;

  // Diagnostic function codes, octal as in the front-end listings
  typedef enum logic [6:0] {
    fnStopClock       = 7'o000,
    fnStartClock      = 7'o001,
    fnStepClock       = 7'o002,
    fnCondStep        = 7'o004,
    fnClearReset      = 7'o006,
    fnSetReset        = 7'o007,
    fnClearRun        = 7'o010,
    fnBurstCtrRh      = 7'o042,
    fnBurstCtrLh      = 7'o043,
    fnClockSrcRate    = 7'o044,
    fnClockDisables   = 7'o045,
    fnResetParRegs    = 7'o046,
    fnMboxDisable     = 7'o047,
    fnCramAddrRh      = 7'o051,
    fnCramAddrLh      = 7'o052,
    fnCramWrite80to85 = 7'o053,
    fnCramWrite60to79 = 7'o054,
    fnCramWrite40to59 = 7'o055,
    fnCramWrite20to39 = 7'o056,
    fnCramWrite00to19 = 7'o057,
    fnEnableKl        = 7'o067,
    fnInitChannels    = 7'o070,
    fnWriteMbox       = 7'o071,
    fnEbusLoad        = 7'o076,
    fnLoadAr          = 7'o077,
    fnCramRead80to85  = 7'o141,
    fnCramRead60to79  = 7'o144,
    fnCramRead40to59  = 7'o145,
    fnCramRead20to39  = 7'o146,
    fnCramRead00to19  = 7'o147
  } diagFunction;

  // Write drives data, function strobes only, read samples the bus
  typedef enum logic [1:0] {cycWrite, cycFunction, cycRead} cycleKind;

  typedef enum logic [2:0] {
    rsCrobar, rsDelay, rsPhaseOne, rsSyncWait, rsStepWait, rsStep, rsPhaseTwo, rsReady
  } resetState;

  typedef enum logic [2:0] {csIdle, csWrite, csRead} cramState;

  //////////////////////////////
  // Timing constants, all in clk cycles
  localparam int crobarCycles     = 100;
  localparam int resetDelayCycles = 10;
  localparam int strobeCycles     = 6;
  // Start to done, including the drive tail and the done cycle
  localparam int busCycleLen      = strobeCycles + 2;
  localparam int syncTries        = 5;
  localparam int syncWaitCycles   = 5;

  //////////////////////////////
  // Master-reset table
  typedef struct packed {
    diagFunction func;
    cycleKind    kind;
    ebusWord     data;
  } resetEntry;

  localparam int resetTableLen = 16;
  // First entry of phase two, the sync loop runs in between
  localparam int phaseTwoStart = 11;

  localparam resetEntry resetTable [0:resetTableLen-1] = '{
    '{fnClearRun,      cycFunction, 36'o0},
    '{fnClockSrcRate,  cycWrite,    36'o0},
    '{fnStopClock,     cycFunction, 36'o0},
    '{fnSetReset,      cycFunction, 36'o0},
    '{fnResetParRegs,  cycWrite,    36'o0},
    '{fnMboxDisable,   cycWrite,    36'o0},
    '{fnBurstCtrLh,    cycWrite,    36'o0},
    '{fnClockDisables, cycWrite,    36'o0},
    '{fnStartClock,    cycFunction, 36'o0},
    '{fnInitChannels,  cycWrite,    36'o0},
    '{fnBurstCtrRh,    cycWrite,    36'o0},
    // Phase two
    '{fnCondStep,      cycFunction, 36'o0},
    '{fnClearReset,    cycFunction, 36'o0},
    '{fnEnableKl,      cycWrite,    36'o0},
    '{fnEbusLoad,      cycWrite,    36'o0},
    '{fnWriteMbox,     cycWrite,    36'o120}
  };

endpackage

//--- logic/frontEndTop.sv
// Front-end sequencer top; control-RAM requests are ignored until the master reset is done
`timescale 1ns/1ps

module frontEndTop (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     changeComingL,
  input  frontEndPkg::ebusWord     ebusIn,
  input  logic                     cramWriteReq,
  input  logic                     cramReadReq,
  input  frontEndPkg::cramAddr     cramAddrIn,
  input  frontEndPkg::cramWord     cramWordIn,
  output frontEndPkg::diagFunction diagFunc,
  output logic                     diagStrobe,
  output frontEndPkg::ebusWord     ebusOut,
  output logic                     ebusDriving,
  output logic                     crobar,
  output logic                     ready,
  output logic                     syncError,
  output frontEndPkg::cramWord     cramWordOut,
  output logic                     cramDone
);

  //////////////////////////////
  // Requester side signals
  logic                     rsStart;
  frontEndPkg::cycleKind    rsKind;
  frontEndPkg::diagFunction rsFunc;
  frontEndPkg::ebusWord     rsData;
  logic                     rsBusy;
  logic                     rsCycleDone;

  logic                     cwStart;
  frontEndPkg::cycleKind    cwKind;
  frontEndPkg::diagFunction cwFunc;
  frontEndPkg::ebusWord     cwData;
  logic                     cwBusy;
  logic                     cwCycleDone;

  // Granted request into the bus cycle
  logic                     busStart;
  frontEndPkg::cycleKind    busKind;
  frontEndPkg::diagFunction busFunc;
  frontEndPkg::ebusWord     busData;
  frontEndPkg::ebusWord     busReadData;
  logic                     busDone;

  // Reset sequencer owns the bus for as long as it is busy
  assign busStart = rsBusy ? rsStart : cwStart;
  assign busKind  = rsBusy ? rsKind  : cwKind;
  assign busFunc  = rsBusy ? rsFunc  : cwFunc;
  assign busData  = rsBusy ? rsData  : cwData;

  // Done goes back only to the granted requester
  assign rsCycleDone = busDone && rsBusy;
  assign cwCycleDone = busDone && !rsBusy && cwBusy;

  diagBusCycle i_busCycle (
    .clk(clk), .reset(reset), .start(busStart), .kind(busKind), .func(busFunc),
    .writeData(busData), .ebusIn(ebusIn), .diagFunc(diagFunc), .diagStrobe(diagStrobe),
    .ebusOut(ebusOut), .ebusDriving(ebusDriving), .readData(busReadData), .done(busDone)
  );

  masterResetSeq i_resetSeq (
    .clk(clk), .reset(reset), .changeComingL(changeComingL), .cycleDone(rsCycleDone),
    .cycleStart(rsStart), .cycleKind(rsKind), .cycleFunc(rsFunc), .cycleData(rsData),
    .crobar(crobar), .busy(rsBusy), .ready(ready), .syncError(syncError)
  );

  cramWordWriter i_cramWriter (
    .clk(clk), .reset(reset), .enable(ready), .writeReq(cramWriteReq),
    .readReq(cramReadReq), .addr(cramAddrIn), .wordIn(cramWordIn),
    .cycleDone(cwCycleDone), .cycleReadData(busReadData), .cycleStart(cwStart),
    .cycleKind(cwKind), .cycleFunc(cwFunc), .cycleData(cwData),
    .wordOut(cramWordOut), .busy(cwBusy), .done(cramDone)
  );

endmodule

//--- logic/masterResetSeq.sv
// Crowbar, master-reset table and memory-box sync; changeComingL is assumed synchronous to clk
`timescale 1ns/1ps

module masterResetSeq (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     changeComingL,
  input  logic                     cycleDone,
  output logic                     cycleStart,
  output frontEndPkg::cycleKind    cycleKind,
  output frontEndPkg::diagFunction cycleFunc,
  output frontEndPkg::ebusWord     cycleData,
  output logic                     crobar,
  output logic                     busy,
  output logic                     ready,
  output logic                     syncError
);

  frontEndPkg::resetState state;

  // Shared by crowbar, delay and sync waits
  logic [6:0] timer;
  logic [3:0] tableIdx;
  logic [2:0] tries;
  // A bus cycle is in flight
  logic       waiting;
  logic       changeComing;
  logic       issuing;

  assign changeComing = !changeComingL;

  assign crobar = state == frontEndPkg::rsCrobar;
  assign ready  = state == frontEndPkg::rsReady;
  assign busy   = !ready;

  //////////////////////////////
  // Bus request

  assign issuing = state == frontEndPkg::rsPhaseOne
                || state == frontEndPkg::rsPhaseTwo
                || state == frontEndPkg::rsStep;

  // One start per cycle, next one only after done
  assign cycleStart = issuing && !waiting;

  always_comb begin
    if (state == frontEndPkg::rsStep) begin
      cycleFunc = frontEndPkg::fnStepClock;
      cycleKind = frontEndPkg::cycFunction;
      cycleData = '0;
    end else begin
      cycleFunc = frontEndPkg::resetTable[tableIdx].func;
      cycleKind = frontEndPkg::resetTable[tableIdx].kind;
      cycleData = frontEndPkg::resetTable[tableIdx].data;
    end
  end

  //////////////////////////////
  // Sequencer

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= frontEndPkg::rsCrobar;
      timer     <= 7'd0;
      tableIdx  <= 4'd0;
      tries     <= 3'd0;
      waiting   <= 1'b0;
      syncError <= 1'b0;
    end else begin
      if (cycleStart) begin
        waiting <= 1'b1;
      end else if (cycleDone) begin
        waiting <= 1'b0;
      end

      case (state)
        frontEndPkg::rsCrobar: begin
          timer <= timer + 7'd1;
          if (timer == 7'(frontEndPkg::crobarCycles - 1)) begin
            timer <= 7'd0;
            state <= frontEndPkg::rsDelay;
          end
        end
        frontEndPkg::rsDelay: begin
          timer <= timer + 7'd1;
          if (timer == 7'(frontEndPkg::resetDelayCycles - 1)) begin
            state <= frontEndPkg::rsPhaseOne;
          end
        end
        frontEndPkg::rsPhaseOne: begin
          if (cycleDone) begin
            tableIdx <= tableIdx + 4'd1;
            // Last phase one entry hands over to the sync loop
            if (tableIdx == 4'(frontEndPkg::phaseTwoStart - 1)) begin
              timer <= 7'd0;
              state <= frontEndPkg::rsSyncWait;
            end
          end
        end
        frontEndPkg::rsSyncWait: begin
          timer <= timer + 7'd1;
          if (timer == 7'(frontEndPkg::syncWaitCycles - 1)) begin
            timer <= 7'd0;
            if (!changeComing) begin
              state <= frontEndPkg::rsPhaseTwo;
            end else if (tries == 3'(frontEndPkg::syncTries)) begin
              // Give up on sync but finish the reset anyway
              syncError <= 1'b1;
              state     <= frontEndPkg::rsPhaseTwo;
            end else begin
              state <= frontEndPkg::rsStepWait;
            end
          end
        end
        frontEndPkg::rsStepWait: begin
          timer <= timer + 7'd1;
          if (timer == 7'(frontEndPkg::syncWaitCycles - 1)) begin
            timer <= 7'd0;
            state <= frontEndPkg::rsStep;
          end
        end
        frontEndPkg::rsStep: begin
          if (cycleDone) begin
            tries <= tries + 3'd1;
            state <= frontEndPkg::rsSyncWait;
          end
        end
        frontEndPkg::rsPhaseTwo: begin
          if (cycleDone) begin
            tableIdx <= tableIdx + 4'd1;
            if (tableIdx == 4'(frontEndPkg::resetTableLen - 1)) begin
              state <= frontEndPkg::rsReady;
            end
          end
        end
        default: begin
          // Ready holds until the next reset
          state <= frontEndPkg::rsReady;
        end
      endcase
    end
  end

endmodule

//--- tests/clockGen.sv
// Free-running 10 ns clock with a power-on reset held for the first 5 rising edges
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    // Release just after the fifth edge
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  end

  always #5 clk = ~clk;

endmodule

//--- tests/frontEndProperties.sv
// Bus timing assertions for diagBusCycle; bound to every instance, silent while reset is high
`timescale 1ns/1ps

module frontEndProperties (
  input logic                  clk,
  input logic                  reset,
  input logic                  accept,
  input logic                  done,
  input logic                  diagStrobe,
  input logic                  ebusDriving,
  input frontEndPkg::cycleKind kind
);

  // Number of failed assertions
  int failCount = 0;

  //////////////////////////////
  // Strobe holds exactly strobeCycles
  strobeWidth: assert property (@(posedge clk) disable iff (reset)
    $rose(diagStrobe) |-> diagStrobe [*frontEndPkg::strobeCycles] ##1 !diagStrobe)
    else begin
      failCount++;
      $error("strobe width differs from strobeCycles");
    end

  // Write drive covers the strobe plus one tail cycle
  driveWindow: assert property (@(posedge clk) disable iff (reset)
    $rose(diagStrobe) && kind == frontEndPkg::cycWrite
      |-> ebusDriving [*frontEndPkg::strobeCycles + 1] ##1 !ebusDriving)
    else begin
      failCount++;
      $error("write drive window wrong");
    end

  // Drive never up without the strobe or its tail
  driveBounded: assert property (@(posedge clk) disable iff (reset)
    ebusDriving |-> diagStrobe || $past(diagStrobe))
    else begin
      failCount++;
      $error("drive outside the strobe window");
    end

  // Fixed latency from a taken start to done
  doneLatency: assert property (@(posedge clk) disable iff (reset)
    accept |-> ##(frontEndPkg::busCycleLen) done)
    else begin
      failCount++;
      $error("done not at fixed latency");
    end

endmodule

bind diagBusCycle frontEndProperties i_props (
  .clk(clk), .reset(reset), .accept(accept), .done(done),
  .diagStrobe(diagStrobe), .ebusDriving(ebusDriving), .kind(kindReg)
);

//--- tests/frontEndTb.sv
// Testbench for frontEndTop; vectors from tests/frontEndTests.txt, run from the project root
`timescale 1ns/1ps

module frontEndTb;

  logic clk;
  logic porReset;
  logic vecReset;
  logic changeComingL;
  frontEndPkg::ebusWord     ebusIn;
  logic                     cramWriteReq;
  logic                     cramReadReq;
  frontEndPkg::cramAddr     cramAddrIn;
  frontEndPkg::cramWord     cramWordIn;
  frontEndPkg::diagFunction diagFunc;
  logic                     diagStrobe;
  frontEndPkg::ebusWord     ebusOut;
  logic                     ebusDriving;
  logic                     crobar;
  logic                     ready;
  logic                     syncError;
  frontEndPkg::cramWord     cramWordOut;
  logic                     cramDone;

  // Vectors
  string   vecName [$];
  int      vecHold [$];
  logic [10:0] vecAddr [$];
  logic [87:0] vecWord [$];
  int numVectors = 0;
  int errorCount = 0;
  int seed = 36194;
  int holdCount;

  //////////////////////////////
  // Machine side model
  logic [0:19] sliceMem [0:2047][0:4];
  frontEndPkg::cramAddr mAddr;
  frontEndPkg::ebusWord readVal;
  logic prevStrobe;
  int   stepsSeen;
  frontEndPkg::diagFunction funcLog [$];
  frontEndPkg::ebusWord     dataLog [$];

  clockGen i_clk (.clk(clk), .reset(porReset));

  frontEndTop i_dut (
    .clk(clk), .reset(porReset || vecReset), .changeComingL(changeComingL), .ebusIn(ebusIn),
    .cramWriteReq(cramWriteReq), .cramReadReq(cramReadReq), .cramAddrIn(cramAddrIn),
    .cramWordIn(cramWordIn), .diagFunc(diagFunc), .diagStrobe(diagStrobe), .ebusOut(ebusOut),
    .ebusDriving(ebusDriving), .crobar(crobar), .ready(ready), .syncError(syncError),
    .cramWordOut(cramWordOut), .cramDone(cramDone)
  );

  function automatic logic [0:19] gatherSlice(input frontEndPkg::ebusWord bus);
    logic [0:19] s;
    for (int j = 0; j < 20; j++) s[j] = bus[8 + (j / 4) * 6 + j % 4];
    return s;
  endfunction

  // Expected slice bus value; groups of four after eight zero bits
  function automatic frontEndPkg::ebusWord sliceBus(input frontEndPkg::cramWord w, input int base,
                                                    input bit evenOnly);
    frontEndPkg::ebusWord b;
    b = '0;
    for (int j = 0; j < 20; j++) begin
      if (!evenOnly || j % 2 == 0) b[8 + (j / 4) * 6 + j % 4] = w[base + j];
    end
    return b;
  endfunction

  task automatic checkValue(input string name, input logic [127:0] expected,
                            input logic [127:0] actual);
    if (expected !== actual) begin
      errorCount++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // Strobe edges logged at the falling clock edge where outputs are settled
  always @(negedge clk) begin
    if (diagStrobe && !prevStrobe) begin
      funcLog.push_back(diagFunc);
      dataLog.push_back(ebusOut);
      case (diagFunc)
        frontEndPkg::fnStepClock:       stepsSeen++;
        frontEndPkg::fnCramAddrRh:      mAddr[5:10] = ebusOut[0:5];
        frontEndPkg::fnCramAddrLh:      mAddr[0:4] = ebusOut[1:5];
        frontEndPkg::fnCramWrite00to19: sliceMem[mAddr][0] = gatherSlice(ebusOut);
        frontEndPkg::fnCramWrite20to39: sliceMem[mAddr][1] = gatherSlice(ebusOut);
        frontEndPkg::fnCramWrite40to59: sliceMem[mAddr][2] = gatherSlice(ebusOut);
        frontEndPkg::fnCramWrite60to79: sliceMem[mAddr][3] = gatherSlice(ebusOut);
        frontEndPkg::fnCramWrite80to85: sliceMem[mAddr][4] = {ebusOut[0:5], 14'b0};
        frontEndPkg::fnCramRead00to19:  readVal = {sliceMem[mAddr][0], 16'b0};
        frontEndPkg::fnCramRead20to39:  readVal = {sliceMem[mAddr][1], 16'b0};
        frontEndPkg::fnCramRead40to59:  readVal = {sliceMem[mAddr][2], 16'b0};
        frontEndPkg::fnCramRead60to79:  readVal = {sliceMem[mAddr][3], 16'b0};
        frontEndPkg::fnCramRead80to85:  readVal = {sliceMem[mAddr][4][0:5], 30'b0};
        default: ;
      endcase
    end
    prevStrobe = diagStrobe;
  end

  // Bound bus timing assertions
  always @(negedge clk) begin
    if (i_dut.i_busCycle.i_props.failCount != 0) begin
      $display("A bus timing assertion failed");
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  // Machine inputs change just after the rising edge
  always @(posedge clk) begin
    #1;
    ebusIn <= readVal;
    changeComingL <= !(stepsSeen < holdCount);
  end

  task automatic pulseRequest(input bit isWrite, input frontEndPkg::cramAddr a,
                              input frontEndPkg::cramWord w);
    @(posedge clk);
    #1;
    cramAddrIn   = a;
    cramWordIn   = w;
    cramWriteReq = isWrite;
    cramReadReq  = !isWrite;
    @(posedge clk);
    #1;
    cramWriteReq = 1'b0;
    cramReadReq  = 1'b0;
  endtask

  task automatic runVector(input int v);
    frontEndPkg::cramWord word;
    frontEndPkg::cramWord expWord;
    frontEndPkg::cramAddr addr;
    frontEndPkg::diagFunction expFunc [$];
    frontEndPkg::ebusWord expData [7];
    int cnt;
    int steps;
    string n;
    n = vecName[v];
    addr = vecAddr[v];
    word = vecWord[v][85:0];
    if (word == '0) word = 86'({$random(seed), $random(seed), $random(seed)});
    holdCount = vecHold[v];
    stepsSeen = 0;
    funcLog.delete();
    dataLog.delete();
    // Reset for five cycles
    @(posedge clk);
    #1 vecReset = 1'b1;
    repeat (5) @(posedge clk);
    #1 vecReset = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (crobar) begin
      checkValue({n, " ready during crowbar"}, 0, ready);
      cnt++;
      @(negedge clk);
    end
    checkValue({n, " crowbar length"}, frontEndPkg::crobarCycles, cnt);
    while (!ready) @(negedge clk);
    // Phase one, the steps, then phase two
    steps = holdCount > frontEndPkg::syncTries ? frontEndPkg::syncTries : holdCount;
    for (int i = 0; i < 11; i++) expFunc.push_back(frontEndPkg::resetTable[i].func);
    repeat (steps) expFunc.push_back(frontEndPkg::fnStepClock);
    for (int i = 11; i < 16; i++) expFunc.push_back(frontEndPkg::resetTable[i].func);
    checkValue({n, " reset cycle count"}, expFunc.size(), funcLog.size());
    for (int i = 0; i < expFunc.size(); i++) begin
      checkValue($sformatf("%s reset code %0d", n, i), expFunc[i], funcLog[i]);
    end
    checkValue({n, " first code clear run"}, frontEndPkg::fnClearRun, funcLog[0]);
    checkValue({n, " write mbox data"}, 36'o120, dataLog[dataLog.size() - 1]);
    checkValue({n, " syncError"}, holdCount > frontEndPkg::syncTries, syncError);

    // Control-RAM write
    funcLog.delete();
    dataLog.delete();
    pulseRequest(1'b1, addr, word);
    while (!cramDone) @(negedge clk);
    expFunc = '{frontEndPkg::fnCramAddrRh, frontEndPkg::fnCramAddrLh,
                frontEndPkg::fnCramWrite60to79, frontEndPkg::fnCramWrite40to59,
                frontEndPkg::fnCramWrite20to39, frontEndPkg::fnCramWrite00to19,
                frontEndPkg::fnCramWrite80to85};
    expData[0] = '0;
    expData[1] = '0;
    expData[6] = '0;
    // Address 5-10 and the special field in bus 0-5, address 0-4 in bus 1-5
    for (int j = 0; j < 6; j++) begin
      expData[0][j] = addr[5 + j];
      expData[6][j] = word[80 + j];
    end
    for (int j = 0; j < 5; j++) expData[1][1 + j] = addr[j];
    expData[2] = sliceBus(word, 60, 1'b1);
    expData[3] = sliceBus(word, 40, 1'b0);
    expData[4] = sliceBus(word, 20, 1'b0);
    expData[5] = sliceBus(word, 0, 1'b0);
    checkValue({n, " write cycle count"}, 7, funcLog.size());
    for (int i = 0; i < 7; i++) begin
      checkValue($sformatf("%s write code %0d", n, i), expFunc[i], funcLog[i]);
      checkValue($sformatf("%s write data %0d", n, i), expData[i], dataLog[i]);
    end

    // Read back, odd bits of 60-79 are never stored
    pulseRequest(1'b0, addr, '0);
    while (!cramDone) @(negedge clk);
    expWord = word;
    for (int b = 61; b < 80; b += 2) expWord[b] = 1'b0;
    checkValue({n, " read word"}, expWord, cramWordOut);
  endtask

  initial begin
    int fd;
    string line;
    string nm;
    int hc;
    logic [10:0] ad;
    logic [87:0] wd;
    vecReset = 1'b0;
    changeComingL = 1'b1;
    ebusIn = '0;
    cramWriteReq = 1'b0;
    cramReadReq = 1'b0;
    cramAddrIn = '0;
    cramWordIn = '0;
    readVal = '0;
    prevStrobe = 1'b0;
    stepsSeen = 0;
    holdCount = 0;
    fd = $fopen("tests/frontEndTests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file");
      $display("RESULT: FAIL");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 2 && line[0] != "#" &&
          $sscanf(line, "%s %d %h %h", nm, hc, ad, wd) == 4) begin
        vecName.push_back(nm);
        vecHold.push_back(hc);
        vecAddr.push_back(ad);
        vecWord.push_back(wd);
      end
    end
    $fclose(fd);
    numVectors = vecName.size();
    if (numVectors == 0) begin
      $display("No test vectors were read from the vector file");
      $display("RESULT: FAIL");
      $fatal(1);
    end
    while (porReset) @(posedge clk);
    for (int v = 0; v < numVectors; v++) runVector(v);
    if (errorCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (numVectors > 0);
    repeat (2000 + 150 * numVectors) @(posedge clk);
    $display("Timeout, the DUT did not finish the vectors in time");
    $display("RESULT: FAIL");
    $fatal(1);
  end

endmodule

//--- tests/frontEndTests.txt
# name holdCount cramAddr(hex) cramWord(hex, 86 bits)
# holdCount 9 holds change-coming for good; a word of 0 is replaced by a random word
syncNone   0 000 3fffffffffffffffffffff
syncOne    1 7ff 2aaaaaaaaaaaaaaaaaaaaa
syncThree  3 2a5 123456789abcdef0123456
syncFive   5 15a 0
syncStuck  9 401 0
syncTwo    2 0c3 0
